/* logic/eth_tx_pkg.sv */
// byte-wide GMII only; tag is 4 bits and the FIFO depth must be a power of two
`default_nettype none

package eth_tx_pkg;

    // preamble and start delimiter
    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hD5;

    // payload bytes before the FCS, padding included
    localparam int min_payload_len = 60;

    localparam int fifo_depth = 128;
    localparam int fifo_addr_w = $clog2(fifo_depth);

    // normal form, the CRC block reflects it
    localparam logic [31:0] crc_poly = 32'h04C1_1DB7;

    // one input byte, tag is taken from the first beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       error;
        logic [3:0] tag;
    } tx_beat_t;

    typedef struct packed {
        logic [7:0] txd;
        logic       tx_en;
        logic       tx_er;
    } gmii_t;

    // completion, error also covers underflow
    typedef struct packed {
        logic [3:0] tag;
        logic       error;
        logic       underflow;
    } tx_cpl_t;

endpackage

`default_nettype wire

/* logic/eth_crc32_byte.sv */
// purely combinational; caller presets the state to all ones and inverts for the FCS
`default_nettype none

module eth_crc32_byte (
    input  wire logic [31:0] crc_in,
    input  wire logic [7:0]  data,
    output logic [31:0]      crc_out
);

    import eth_tx_pkg::*;

    logic [31:0] poly_rev;

    // lsb-first shift needs the bit-reversed polynomial
    assign poly_rev = {<<{crc_poly}};

    always_comb begin
        logic [31:0] crc;

        crc = crc_in ^ {24'h00_0000, data};
        // one step per data bit
        for (int i = 0; i < 8; i++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ poly_rev;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_out = crc;
    end

endmodule

`default_nettype wire

/* logic/tx_byte_fifo.sv */
// no back-pressure on the write side; a write into a full buffer is lost and flagged
`default_nettype none

module tx_byte_fifo (
    input  wire logic                 clk,
    input  wire logic                 reset_crc,
    input  wire logic                 wr_valid,
    input  wire eth_tx_pkg::tx_beat_t wr_beat,
    input  wire logic                 pop,
    output eth_tx_pkg::tx_beat_t      head,
    output logic                      not_empty,
    output logic                      overflow
);

    import eth_tx_pkg::*;

    tx_beat_t mem [fifo_depth];

    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_addr_w:0]   count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full = count == (fifo_addr_w + 1)'(fifo_depth);
    assign not_empty = count != '0;
    assign do_wr = wr_valid && !full;
    assign do_rd = pop && not_empty;

    // head is read straight from the array
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= wr_valid && full;

            // pointers wrap on their own, depth is a power of two
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_wr, do_rd})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/gmii_tx_framer.sv */
// GMII byte mode only; the rest of an underflowed frame is dropped after the gap count
`default_nettype none

module gmii_tx_framer (
    input  wire logic                 clk,
    input  wire logic                 reset_crc,
    input  wire eth_tx_pkg::tx_beat_t head,
    input  wire logic                 not_empty,
    output logic                      pop,
    input  wire logic [7:0]           cfg_ifg,
    input  wire logic                 cfg_tx_enable,
    output eth_tx_pkg::gmii_t         gmii,
    output eth_tx_pkg::tx_cpl_t       cpl,
    output logic                      cpl_valid,
    output logic                      start_packet,
    output logic                      underflow
);

    import eth_tx_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_pre,
        st_payload,
        st_pad,
        st_fcs,
        st_ifg,
        st_drop
    } state_t;

    state_t state;
    state_t state_next;

    // preamble and FCS byte index
    logic [2:0]  cnt;
    logic [2:0]  cnt_next;
    logic [6:0]  len_cnt;
    logic [6:0]  len_next;
    logic [7:0]  gap_cnt;
    logic [7:0]  gap_next;
    logic [3:0]  tag;
    logic [3:0]  tag_next;
    logic        frame_err;
    logic        err_next;
    logic        uflow;
    logic        uflow_next;

    logic        crc_clear;
    logic        send_byte;
    logic        send_fcs;
    logic [7:0]  byte_out;
    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic [31:0] fcs_word;

    gmii_t       gmii_next;
    logic        cpl_valid_next;
    logic        start_packet_next;
    logic        underflow_next;

    eth_crc32_byte i_eth_crc32_byte (
        .crc_in  (crc_state),
        .data    (byte_out),
        .crc_out (crc_next)
    );

    assign fcs_word = ~crc_state;

    always_comb begin
        state_next = state;
        cnt_next = cnt;
        len_next = len_cnt;
        gap_next = gap_cnt;
        tag_next = tag;
        err_next = frame_err;
        uflow_next = uflow;
        pop = 1'b0;
        crc_clear = 1'b0;
        send_byte = 1'b0;
        send_fcs = 1'b0;
        byte_out = 8'h00;
        gmii_next = '0;
        cpl_valid_next = 1'b0;
        start_packet_next = 1'b0;
        underflow_next = 1'b0;

        case (state)
            st_idle: begin
                crc_clear = 1'b1;
                cnt_next = 3'd0;
                len_next = 7'd0;
                err_next = 1'b0;
                uflow_next = 1'b0;
                if (not_empty && cfg_tx_enable) begin
                    // head is the first beat of the next frame
                    tag_next = head.tag;
                    gmii_next.txd = eth_pre;
                    gmii_next.tx_en = 1'b1;
                    cnt_next = 3'd1;
                    state_next = st_pre;
                end
            end
            st_pre: begin
                crc_clear = 1'b1;
                gmii_next.tx_en = 1'b1;
                if (cnt == 3'd7) begin
                    gmii_next.txd = eth_sfd;
                    start_packet_next = 1'b1;
                    cnt_next = 3'd0;
                    state_next = st_payload;
                end else begin
                    gmii_next.txd = eth_pre;
                    cnt_next = cnt + 3'd1;
                end
            end
            st_payload: begin
                if (not_empty) begin
                    pop = 1'b1;
                    send_byte = 1'b1;
                    byte_out = head.data;
                    err_next = frame_err | head.error;
                    if (head.last) begin
                        if (len_cnt + 7'd1 < 7'(min_payload_len)) begin
                            state_next = st_pad;
                        end else begin
                            state_next = st_fcs;
                        end
                    end
                end else begin
                    // buffer ran dry before last, close the frame as bad
                    underflow_next = 1'b1;
                    uflow_next = 1'b1;
                    if (len_cnt + 7'd1 < 7'(min_payload_len)) begin
                        send_byte = 1'b1;
                        state_next = st_pad;
                    end else if (len_cnt < 7'(min_payload_len)) begin
                        send_byte = 1'b1;
                        state_next = st_fcs;
                    end else begin
                        send_fcs = 1'b1;
                        state_next = st_fcs;
                    end
                end
            end
            st_pad: begin
                send_byte = 1'b1;
                if (len_cnt + 7'd1 >= 7'(min_payload_len)) begin
                    state_next = st_fcs;
                end
            end
            st_fcs: begin
                send_fcs = 1'b1;
                if (cnt == 3'd3) begin
                    gap_next = 8'd0;
                    state_next = st_ifg;
                end
            end
            st_ifg: begin
                cpl_valid_next = gap_cnt == 8'd0;
                gap_next = gap_cnt + 8'd1;
                if ({1'b0, gap_cnt} + 9'd1 >= {1'b0, cfg_ifg}) begin
                    state_next = uflow ? st_drop : st_idle;
                end
            end
            st_drop: begin
                // discard the tail of an underflowed frame
                if (not_empty) begin
                    pop = 1'b1;
                    if (head.last) begin
                        state_next = st_idle;
                    end
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase

        // payload or pad byte, folded into the CRC
        if (send_byte) begin
            gmii_next.txd = byte_out;
            gmii_next.tx_en = 1'b1;
            if (len_cnt < 7'(min_payload_len)) begin
                len_next = len_cnt + 7'd1;
            end
        end

        // fcs goes out lsb first
        if (send_fcs) begin
            gmii_next.txd = fcs_word[{cnt[1:0], 3'b000} +: 8];
            gmii_next.tx_en = 1'b1;
            gmii_next.tx_er = err_next | uflow_next;
            cnt_next = cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= st_idle;
            cnt <= 3'd0;
            len_cnt <= 7'd0;
            gap_cnt <= 8'd0;
            frame_err <= 1'b0;
            uflow <= 1'b0;
            gmii <= '0;
            cpl_valid <= 1'b0;
            start_packet <= 1'b0;
            underflow <= 1'b0;
        end else begin
            state <= state_next;
            cnt <= cnt_next;
            len_cnt <= len_next;
            gap_cnt <= gap_next;
            frame_err <= err_next;
            uflow <= uflow_next;
            gmii <= gmii_next;
            cpl_valid <= cpl_valid_next;
            start_packet <= start_packet_next;
            underflow <= underflow_next;
        end
    end

    always_ff @(posedge clk) begin
        tag <= tag_next;
        if (crc_clear) begin
            crc_state <= '1;
        end else if (send_byte) begin
            crc_state <= crc_next;
        end
        if (cpl_valid_next) begin
            cpl <= '{tag: tag, error: frame_err | uflow, underflow: uflow};
        end
    end

endmodule

`default_nettype wire

/* logic/gmii_tx_top.sv */
// tx_valid is a strobe with no back-pressure; watch overflow to catch lost bytes
`default_nettype none

module gmii_tx_top (
    input  wire logic                 clk,
    input  wire logic                 reset_crc,
    input  wire logic                 tx_valid,
    input  wire eth_tx_pkg::tx_beat_t tx_beat,
    input  wire logic [7:0]           cfg_ifg,
    input  wire logic                 cfg_tx_enable,
    output eth_tx_pkg::gmii_t         gmii,
    output eth_tx_pkg::tx_cpl_t       cpl,
    output logic                      cpl_valid,
    output logic                      start_packet,
    output logic                      underflow,
    output logic                      overflow
);

    import eth_tx_pkg::*;

    tx_beat_t head;
    logic     not_empty;
    logic     pop;

    tx_byte_fifo i_tx_byte_fifo (
        .clk       (clk),
        .reset_crc (reset_crc),
        .wr_valid  (tx_valid),
        .wr_beat   (tx_beat),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    gmii_tx_framer i_gmii_tx_framer (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .head          (head),
        .not_empty     (not_empty),
        .pop           (pop),
        .cfg_ifg       (cfg_ifg),
        .cfg_tx_enable (cfg_tx_enable),
        .gmii          (gmii),
        .cpl           (cpl),
        .cpl_valid     (cpl_valid),
        .start_packet  (start_packet),
        .underflow     (underflow)
    );

endmodule

`default_nettype wire

/* bench/gmii_tx_tb.sv */
// self-checking; run from the project root so the cases file resolves; at most 64 cases
`default_nettype none

module gmii_tx_tb;

    import eth_tx_pkg::*;

    localparam int max_cases = 64;
    localparam int cycles_per_case = 2000;

    logic       clk;
    logic       reset_crc;
    logic       tx_valid;
    tx_beat_t   tx_beat;
    logic [7:0] cfg_ifg;
    logic       cfg_tx_enable;
    gmii_t      gmii;
    tx_cpl_t    cpl;
    logic       cpl_valid;
    logic       start_packet;
    logic       underflow;
    logic       overflow;

    int          case_len [max_cases];
    int          case_first [max_cases];
    int          case_tag [max_cases];
    int          case_err [max_cases];
    int          case_gap [max_cases];
    logic [31:0] case_residue [max_cases];
    int          case_cerr [max_cases];
    int          case_cufl [max_cases];
    int          case_count = 0;
    bit          cases_loaded = 1'b0;

    // capture state
    logic [7:0] burst_bytes [$];
    logic       burst_er [$];
    logic       in_burst = 1'b0;
    int         low_cycles = 0;
    int         ifg_floor = 0;
    int         burst_count = 0;
    int         cpl_count = 0;
    int         uflow_strobes = 0;

    gmii_tx_top i_gmii_tx_top (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .tx_valid      (tx_valid),
        .tx_beat       (tx_beat),
        .cfg_ifg       (cfg_ifg),
        .cfg_tx_enable (cfg_tx_enable),
        .gmii          (gmii),
        .cpl           (cpl),
        .cpl_valid     (cpl_valid),
        .start_packet  (start_packet),
        .underflow     (underflow),
        .overflow      (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // non-reflected register, data bits fed lsb first
    function automatic logic [31:0] crc_step_msb(input logic [31:0] crc_in, input logic [7:0] d);
        logic [31:0] c;
        logic        fb;

        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            fb = c[31] ^ d[i];
            c = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ crc_poly;
            end
        end
        return c;
    endfunction

    task automatic load_cases();
        int    fd;
        int    n;
        int    v_len, v_first, v_tag, v_err, v_gap, v_res, v_cerr, v_cufl;
        string line;

        fd = $fopen("bench/gmii_tx_cases.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open bench/gmii_tx_cases.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %d %d %h %d %d", v_len, v_first, v_tag,
                                v_err, v_gap, v_res, v_cerr, v_cufl);
                    if (n == 8 && case_count < max_cases) begin
                        case_len[case_count] = v_len;
                        case_first[case_count] = v_first;
                        case_tag[case_count] = v_tag;
                        case_err[case_count] = v_err;
                        case_gap[case_count] = v_gap;
                        case_residue[case_count] = v_res;
                        case_cerr[case_count] = v_cerr;
                        case_cufl[case_count] = v_cufl;
                        case_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_frame(input int c);
        for (int i = 0; i < case_len[c]; i++) begin
            @(negedge clk);
            tx_valid = 1'b1;
            tx_beat.data = 8'(case_first[c] + i);
            tx_beat.last = (i == case_len[c] - 1);
            tx_beat.error = (case_err[c] != 0);
            tx_beat.tag = 4'(case_tag[c]);
            if (case_gap[c] != 0 && i == case_gap[c] - 1) begin
                // source stalls so the framer runs dry
                @(negedge clk);
                tx_valid = 1'b0;
                repeat (199) @(negedge clk);
            end
        end
        @(negedge clk);
        tx_valid = 1'b0;
    endtask

    task automatic check_burst(input int c);
        int          sent;
        int          body;
        int          total;
        logic [7:0]  want;
        logic [31:0] crc;

        sent = (case_gap[c] != 0) ? case_gap[c] : case_len[c];
        body = (sent < min_payload_len) ? min_payload_len : sent;
        total = 8 + body + 4;
        assert (burst_bytes.size() == total) else
            fail_run($sformatf("MISMATCH at %0t: case %0d burst of %0d bytes, expected %0d",
                               $time, c, burst_bytes.size(), total));
        crc = '1;
        for (int i = 0; i < total; i++) begin
            want = (i < 7) ? eth_pre : (i == 7) ? eth_sfd :
                   (i < 8 + sent) ? 8'(case_first[c] + i - 8) : 8'h00;
            assert (i >= 8 + body || burst_bytes[i] == want) else
                fail_run($sformatf("MISMATCH at %0t: case %0d byte %0d is %02h, expected %02h",
                                   $time, c, i, burst_bytes[i], want));
            assert (burst_er[i] == (i >= total - 4 && case_cerr[c] != 0)) else
                fail_run($sformatf("MISMATCH at %0t: case %0d tx_er wrong on byte %0d",
                                   $time, c, i));
            if (i >= 8) begin
                crc = crc_step_msb(crc, burst_bytes[i]);
            end
        end
        // payload plus a correct FCS leaves the fixed residue
        assert (crc == case_residue[c]) else
            fail_run($sformatf("MISMATCH at %0t: case %0d FCS gives residue %08h, expected %08h",
                               $time, c, crc, case_residue[c]));
    endtask

    task automatic check_completion(input int c);
        assert (cpl_valid) else
            fail_run($sformatf("MISMATCH at %0t: no completion right after burst %0d", $time, c));
        assert (cpl.tag == 4'(case_tag[c]) && cpl.error == (case_cerr[c] != 0)
                && cpl.underflow == (case_cufl[c] != 0)) else
            fail_run($sformatf("MISMATCH at %0t: case %0d completion tag %0h err %0b uflow %0b",
                               $time, c, cpl.tag, cpl.error, cpl.underflow));
        assert (uflow_strobes == case_cufl[c]) else
            fail_run($sformatf("MISMATCH at %0t: case %0d saw %0d underflow strobes",
                               $time, c, uflow_strobes));
        uflow_strobes = 0;
    endtask

    // outputs are registered, sampled at the rising edge
    always @(posedge clk) begin
        if (!reset_crc) begin
            assert (!overflow) else
                fail_run($sformatf("MISMATCH at %0t: FIFO overflow strobed", $time));
            if (underflow) begin
                uflow_strobes++;
            end
            if (gmii.tx_en) begin
                if (!in_burst) begin
                    assert (burst_count < case_count && low_cycles >=
                            ((ifg_floor < int'(cfg_ifg)) ? ifg_floor : int'(cfg_ifg))) else
                        fail_run($sformatf("MISMATCH at %0t: burst %0d after %0d idle cycles",
                                           $time, burst_count, low_cycles));
                    in_burst = 1'b1;
                    burst_bytes.delete();
                    burst_er.delete();
                end
                assert (start_packet == (burst_bytes.size() == 7) && !cpl_valid) else
                    fail_run($sformatf("MISMATCH at %0t: start_packet or cpl_valid misplaced",
                                       $time));
                burst_bytes.push_back(gmii.txd);
                burst_er.push_back(gmii.tx_er);
            end else if (in_burst) begin
                in_burst = 1'b0;
                check_burst(burst_count);
                check_completion(burst_count);
                ifg_floor = cfg_ifg;
                low_cycles = 1;
                burst_count++;
                cpl_count++;
            end else begin
                assert (!cpl_valid && !start_packet && !gmii.tx_er) else
                    fail_run($sformatf("MISMATCH at %0t: strobe while the line is idle", $time));
                low_cycles++;
            end
        end
    end

    initial begin
        wait (cases_loaded);
        repeat (case_count * cycles_per_case) @(posedge clk);
        fail_run($sformatf("timeout: run not finished after %0d clock cycles",
                           case_count * cycles_per_case));
    end

    initial begin
        tx_valid = 1'b0;
        tx_beat = '0;
        cfg_ifg = 8'd12;
        cfg_tx_enable = 1'b0;
        reset_crc = 1'b1;
        void'($urandom(32'h48f2_9a71));
        load_cases();
        cases_loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_crc = 1'b0;
        cfg_tx_enable = 1'b1;
        for (int c = 0; c < case_count; c++) begin
            @(negedge clk);
            cfg_ifg = 8'(12 + ($urandom % 9));
            write_frame(c);
            wait (cpl_count > c);
        end
        repeat (50) @(posedge clk);
        if (case_count > 0 && burst_count == case_count) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run("no cases were loaded or a frame never left the transmitter");
        end
    end

endmodule

`default_nettype wire

/* gmii_tx.f */
logic/eth_tx_pkg.sv
logic/eth_crc32_byte.sv
logic/tx_byte_fifo.sv
logic/gmii_tx_framer.sv
logic/gmii_tx_top.sv
bench/gmii_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := gmii_tx_tb
RTL_TOP   := gmii_tx_top
FILELIST  := gmii_tx.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/gmii_tx_cases.txt */
# len(dec) first(hex) tag(hex) err gap residue(hex) cpl_err cpl_underflow
# gap 0 means no stall; residue is the MSB-first CRC register after payload and FCS
60 00 1 0 0 c704dd7b 0 0
1 a5 2 0 0 c704dd7b 0 0
59 10 3 0 0 c704dd7b 0 0
61 20 4 0 0 c704dd7b 0 0
64 ff 5 0 0 c704dd7b 0 0
100 37 6 0 0 c704dd7b 0 0
46 80 7 1 0 c704dd7b 1 0
30 40 9 0 10 c704dd7b 1 1
12 c3 a 0 0 c704dd7b 0 0
200 5a b 0 0 c704dd7b 0 0
80 90 c 0 59 c704dd7b 1 1
60 11 d 1 0 c704dd7b 1 0
90 22 e 0 70 c704dd7b 1 1
75 33 0 1 20 c704dd7b 1 1
40 77 3 0 39 c704dd7b 1 1
61 aa 6 0 60 c704dd7b 1 1
3 bb 7 0 1 c704dd7b 1 1
1 dd 9 1 0 c704dd7b 1 0
